// ==== fault_arbiter.sv ====
`timescale 1ns/1ps

module fault_arbiter (
  // Global enables and lock
  input  logic                                 sys_en,
  input  logic                                 ext_en,
  input  logic                                 lock_viol,
  // Pre-start config flags
  input  logic [hw_mgr_pkg::N_CFG_CHECKS-1:0]  cfg_oob,
  // Per-board fault vectors
  input  logic [hw_mgr_pkg::N_BOARDS-1:0]      shutdown_sense,
  input  logic [hw_mgr_pkg::N_BOARDS-1:0]      over_thresh,
  input  logic [hw_mgr_pkg::N_BOARDS-1:0]      dac_boot_fail,
  input  logic [hw_mgr_pkg::N_BOARDS-1:0]      adc_boot_fail,
  // Pre-start result
  output logic                                 start_fault,
  output logic [hw_mgr_pkg::STATUS_W-1:0]      start_code,
  // Boot result
  output logic                                 boot_fault,
  output logic [hw_mgr_pkg::STATUS_W-1:0]      boot_code,
  output logic [hw_mgr_pkg::BOARD_W-1:0]       boot_board,
  // Runtime result
  output logic                                 run_fault,
  output logic [hw_mgr_pkg::STATUS_W-1:0]      run_code,
  output logic [hw_mgr_pkg::BOARD_W-1:0]       run_board
);
  import hw_mgr_pkg::*;

  localparam int CFG_IDX_W = $clog2(N_CFG_CHECKS);

  logic [CFG_IDX_W-1:0] cfg_idx;  // Lowest flagged config check

  // Lowest set config flag
  always_comb begin : cfg_scan
    cfg_idx = '0;
    for (int i = N_CFG_CHECKS - 1; i >= 0; i--) begin
      if (cfg_oob[i]) cfg_idx = CFG_IDX_W'(i);
    end
  end

  // Checked in IDLE before anything is powered
  always_comb begin : start_arb
    start_fault = !ext_en || (|cfg_oob);
    if (!ext_en) begin
      start_code = STS_EXT_SHUTDOWN;  // Deadman first
    end else begin
      start_code = STS_CFG_OOB_BASE + STATUS_W'(cfg_idx);
    end
  end

  // Channel boot checks while SPI starts up
  always_comb begin : boot_arb
    boot_fault = (|dac_boot_fail) || (|adc_boot_fail);
    if (|dac_boot_fail) begin
      boot_code  = STS_DAC_BOOT_FAIL;   // DAC wins over ADC
      boot_board = first_board(dac_boot_fail);
    end else begin
      boot_code  = STS_ADC_BOOT_FAIL;
      boot_board = first_board(adc_boot_fail);
    end
  end

  // Runtime shutdown conditions, highest priority first
  always_comb begin : run_arb
    run_fault = 1'b1;
    run_board = '0;
    if (!sys_en) begin
      run_code = STS_PS_SHUTDOWN;        // Software turned it off
    end else if (lock_viol) begin
      run_code = STS_LOCK_VIOL;
    end else if (|shutdown_sense) begin
      run_code  = STS_SHUTDOWN_SENSE;    // Board tripped itself
      run_board = first_board(shutdown_sense);
    end else if (!ext_en) begin
      run_code = STS_EXT_SHUTDOWN;
    end else if (|over_thresh) begin
      run_code  = STS_OVER_THRESH;
      run_board = first_board(over_thresh);
    end else begin
      run_fault = 1'b0;                  // All clear
      run_code  = STS_OK;
    end
  end

endmodule

// ==== hw_mgr_pkg.sv ====
package hw_mgr_pkg;

  // Board and field widths
  localparam int N_BOARDS     = 8;   // Amplifier boards
  localparam int BOARD_W      = 3;   // Board number field
  localparam int N_CFG_CHECKS = 10;  // Config out-of-bounds flags
  localparam int TIMER_W      = 32;  // Timer and delay values
  localparam int STATUS_W     = 25;  // Status code field

  // Manager states, encoding is visible in the status word
  typedef enum logic [3:0] {
    IDLE              = 4'd1,
    CONFIRM_SPI_RST   = 4'd2,
    POWER_ON_CTRL_BRD = 4'd3,
    CONFIRM_SPI_START = 4'd4,
    POWER_ON_AMP_BRD  = 4'd5,
    AMP_POWER_WAIT    = 4'd6,
    RUNNING           = 4'd7,
    HALTING           = 4'd8,
    HALTED            = 4'd9
  } state_t;

  // Basic system
  localparam logic [STATUS_W-1:0] STS_OK          = 25'h0001;
  localparam logic [STATUS_W-1:0] STS_PS_SHUTDOWN = 25'h0002;

  // SPI subsystem
  localparam logic [STATUS_W-1:0] STS_SPI_RESET_TIMEOUT = 25'h0100;
  localparam logic [STATUS_W-1:0] STS_SPI_START_TIMEOUT = 25'h0101;

  // Config lock and out-of-bounds, flag i reports base + i
  localparam logic [STATUS_W-1:0] STS_LOCK_VIOL    = 25'h0200;
  localparam logic [STATUS_W-1:0] STS_CFG_OOB_BASE = 25'h0201;

  // Shutdown sense and external enable
  localparam logic [STATUS_W-1:0] STS_SHUTDOWN_SENSE = 25'h0300;
  localparam logic [STATUS_W-1:0] STS_EXT_SHUTDOWN   = 25'h0301;

  // Integrator threshold
  localparam logic [STATUS_W-1:0] STS_OVER_THRESH = 25'h0400;

  // Channel boot failures
  localparam logic [STATUS_W-1:0] STS_DAC_BOOT_FAIL = 25'h0600;
  localparam logic [STATUS_W-1:0] STS_ADC_BOOT_FAIL = 25'h0700;

  // Minimum wait before spi_off is trusted after reset
  localparam logic [TIMER_W-1:0] SPI_SETTLE_CYCLES = 32'd10;

  // Lowest set bit of a per-board vector, 0 when none set
  function automatic logic [BOARD_W-1:0] first_board(input logic [N_BOARDS-1:0] v);
    logic [BOARD_W-1:0] idx;
    idx = '0;
    for (int i = N_BOARDS - 1; i >= 0; i--) begin
      if (v[i]) idx = BOARD_W'(i);  // Scan down so lowest wins
    end
    return idx;
  endfunction

endpackage

// ==== hw_sequencer.sv ====
`timescale 1ns/1ps

module hw_sequencer #(
  parameter int unsigned SHUTDOWN_FORCE_DELAY = 10000000,   // 100 ms before reset pulse
  parameter int unsigned SHUTDOWN_RESET_PULSE = 10000,      // 100 us pulse width
  parameter int unsigned SHUTDOWN_RESET_DELAY = 10000000,   // 100 ms before running
  parameter int unsigned SPI_RESET_WAIT       = 100000000,  // 1 s for SPI to show off
  parameter int unsigned SPI_START_WAIT       = 100000000   // 1 s for SPI to start
) (
  input  logic                             clk,
  input  logic                             aresetn,
  input  logic                             sys_en,
  input  logic                             ext_en,
  input  logic                             spi_off,
  // Arbitrated faults
  input  logic                             start_fault,
  input  logic [hw_mgr_pkg::STATUS_W-1:0]  start_code,
  input  logic                             boot_fault,
  input  logic [hw_mgr_pkg::STATUS_W-1:0]  boot_code,
  input  logic [hw_mgr_pkg::BOARD_W-1:0]   boot_board,
  input  logic                             run_fault,
  input  logic [hw_mgr_pkg::STATUS_W-1:0]  run_code,
  input  logic [hw_mgr_pkg::BOARD_W-1:0]   run_board,
  // Timer
  input  logic [hw_mgr_pkg::TIMER_W-1:0]   count,
  input  logic                             expired,
  output logic                             timer_clear,
  output logic [hw_mgr_pkg::TIMER_W-1:0]   timer_limit,
  // State and status
  output hw_mgr_pkg::state_t               state,
  output hw_mgr_pkg::state_t               state_next,
  output logic [hw_mgr_pkg::STATUS_W-1:0]  status_code,
  output logic [hw_mgr_pkg::BOARD_W-1:0]   board_num
);
  import hw_mgr_pkg::*;

  logic                halt;        // Go to HALTING this cycle
  logic [STATUS_W-1:0] halt_code;   // Code captured on halt
  logic [BOARD_W-1:0]  halt_board;  // Board captured on halt

  // Timer restarts on every state entry
  assign timer_clear = (state_next != state);

  // Delay of the current state
  always_comb begin : limit_sel
    case (state)
      CONFIRM_SPI_RST:   timer_limit = TIMER_W'(SPI_RESET_WAIT);
      POWER_ON_CTRL_BRD: timer_limit = TIMER_W'(SHUTDOWN_FORCE_DELAY);
      CONFIRM_SPI_START: timer_limit = TIMER_W'(SPI_START_WAIT);
      POWER_ON_AMP_BRD:  timer_limit = TIMER_W'(SHUTDOWN_RESET_PULSE);
      AMP_POWER_WAIT:    timer_limit = TIMER_W'(SHUTDOWN_RESET_DELAY);
      default:           timer_limit = '0;  // Untimed states
    endcase
  end

  always_comb begin : next_state
    state_next = state;
    halt       = 1'b0;
    halt_code  = STS_EXT_SHUTDOWN;  // Most sequencing halts are deadman
    halt_board = '0;
    case (state)
      // Wait for enable, then check config before locking it
      IDLE: begin
        if (sys_en) begin
          if (start_fault) begin
            halt      = 1'b1;
            halt_code = start_code;
          end else begin
            state_next = CONFIRM_SPI_RST;
          end
        end
      end
      // SPI must report off before the control board powers up
      CONFIRM_SPI_RST: begin
        if (!ext_en) begin
          halt = 1'b1;
        end else if ((count >= SPI_SETTLE_CYCLES) && spi_off) begin
          state_next = POWER_ON_CTRL_BRD;
        end else if (expired) begin
          halt      = 1'b1;
          halt_code = STS_SPI_RESET_TIMEOUT;
        end
      end
      // Let DAC/ADC power up after force release
      POWER_ON_CTRL_BRD: begin
        if (!ext_en) begin
          halt = 1'b1;
        end else if (expired) begin
          state_next = CONFIRM_SPI_START;
        end
      end
      // SPI running once spi_off drops
      CONFIRM_SPI_START: begin
        if (!ext_en) begin
          halt = 1'b1;
        end else if (!spi_off) begin
          state_next = POWER_ON_AMP_BRD;
        end else if (boot_fault) begin
          halt       = 1'b1;
          halt_code  = boot_code;
          halt_board = boot_board;
        end else if (expired) begin
          halt      = 1'b1;
          halt_code = STS_SPI_START_TIMEOUT;
        end
      end
      // Shutdown reset pulse
      POWER_ON_AMP_BRD: begin
        if (!ext_en) begin
          halt = 1'b1;
        end else if (expired) begin
          state_next = AMP_POWER_WAIT;
        end
      end
      // Power stage settling before buffers open
      AMP_POWER_WAIT: begin
        if (!ext_en) begin
          halt = 1'b1;
        end else if (expired) begin
          state_next = RUNNING;
        end
      end
      RUNNING: begin
        if (run_fault) begin
          halt       = 1'b1;
          halt_code  = run_code;
          halt_board = run_board;
        end
      end
      HALTING: state_next = HALTED;  // Single cycle
      HALTED: begin
        if (!sys_en) state_next = IDLE;  // Software acknowledged
      end
      default: state_next = HALTED;  // Illegal encoding
    endcase
    if (halt) state_next = HALTING;
  end

  // State and status registers
  always_ff @(posedge clk) begin
    if (!aresetn) begin
      state       <= IDLE;
      status_code <= STS_OK;
      board_num   <= '0;
    end else begin
      state <= state_next;
      if (halt) begin
        status_code <= halt_code;   // Hold cause until acknowledged
        board_num   <= halt_board;
      end else if ((state == HALTED) && (state_next == IDLE)) begin
        status_code <= STS_OK;
        board_num   <= '0;
      end
    end
  end

endmodule

// ==== power_ctrl.sv ====
`timescale 1ns/1ps

module power_ctrl (
  input  logic                clk,
  input  logic                aresetn,
  input  hw_mgr_pkg::state_t  state,
  input  hw_mgr_pkg::state_t  state_next,
  output logic                unlock_cfg,         // Config registers writable
  output logic                spi_clk_gate,       // SPI clock power
  output logic                spi_en,             // SPI subsystem enable
  output logic                shutdown_sense_en,  // Board sense armed
  output logic                block_bufs,         // Hold PL side of buffers
  output logic                n_shutdown_force,   // Shutdown force, active low
  output logic                n_shutdown_rst,     // Shutdown reset, active low
  output logic                ps_interrupt
);
  import hw_mgr_pkg::*;

  // Decoded from next state so outputs switch with the state register
  always_ff @(posedge clk) begin
    if (!aresetn) begin
      unlock_cfg        <= 1'b1;
      spi_clk_gate      <= 1'b0;
      spi_en            <= 1'b0;
      shutdown_sense_en <= 1'b0;
      block_bufs        <= 1'b1;
      n_shutdown_force  <= 1'b0;
      n_shutdown_rst    <= 1'b1;
      ps_interrupt      <= 1'b0;
    end else begin
      // Control board powered from here through RUNNING
      n_shutdown_force <= state_next inside {POWER_ON_CTRL_BRD, CONFIRM_SPI_START,
                                             POWER_ON_AMP_BRD, AMP_POWER_WAIT, RUNNING};
      // SPI live once the control board is up
      spi_en       <= state_next inside {CONFIRM_SPI_START, POWER_ON_AMP_BRD,
                                         AMP_POWER_WAIT, RUNNING};
      spi_clk_gate <= state_next inside {CONFIRM_SPI_START, POWER_ON_AMP_BRD,
                                         AMP_POWER_WAIT, RUNNING};
      n_shutdown_rst    <= (state_next != POWER_ON_AMP_BRD);  // Reset pulse
      shutdown_sense_en <= (state_next == RUNNING);
      block_bufs        <= (state_next != RUNNING);
      unlock_cfg        <= (state_next == IDLE) || (state_next == HALTED);
      // One-cycle pulse on entry only
      ps_interrupt <= (state_next != state) &&
                      ((state_next == RUNNING) || (state_next == HALTED));
    end
  end

endmodule

// ==== project.f ====
hw_mgr_pkg.sv
seq_timer.sv
fault_arbiter.sv
power_ctrl.sv
hw_sequencer.sv
shim_hw_manager.sv
tb_clock_gen.sv
tb_shim_hw_manager.sv

// ==== seq_timer.sv ====
`timescale 1ns/1ps

module seq_timer (
  input  logic                            clk,
  input  logic                            aresetn,
  input  logic                            clear,    // Restart from zero
  input  logic [hw_mgr_pkg::TIMER_W-1:0]  limit,    // Compare value
  output logic [hw_mgr_pkg::TIMER_W-1:0]  count,
  output logic                            expired
);
  import hw_mgr_pkg::*;

  // Limit reached, stays high until cleared
  assign expired = (count >= limit);

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;               // New state entered
    end else if (!expired) begin
      count <= count + 1'b1;     // One tick per cycle
    end
    // Held at the limit once expired
  end

endmodule

// ==== shim_hw_manager.sv ====
`timescale 1ns/1ps

module shim_hw_manager #(
  parameter int unsigned SHUTDOWN_FORCE_DELAY = 10000000,   // 100 ms at 100 MHz
  parameter int unsigned SHUTDOWN_RESET_PULSE = 10000,      // 100 us
  parameter int unsigned SHUTDOWN_RESET_DELAY = 10000000,   // 100 ms
  parameter int unsigned SPI_RESET_WAIT       = 100000000,  // 1 s
  parameter int unsigned SPI_START_WAIT       = 100000000   // 1 s
) (
  input  logic                                 clk,
  input  logic                                 aresetn,
  input  logic                                 sys_en,     // Turn the system on
  input  logic                                 spi_off,    // SPI subsystem idle
  input  logic                                 ext_en,     // Deadman enable
  input  logic                                 lock_viol,  // Config written while locked
  input  logic [hw_mgr_pkg::N_CFG_CHECKS-1:0]  cfg_oob,
  input  logic [hw_mgr_pkg::N_BOARDS-1:0]      shutdown_sense,
  input  logic [hw_mgr_pkg::N_BOARDS-1:0]      over_thresh,
  input  logic [hw_mgr_pkg::N_BOARDS-1:0]      dac_boot_fail,
  input  logic [hw_mgr_pkg::N_BOARDS-1:0]      adc_boot_fail,
  output logic                                 unlock_cfg,
  output logic                                 spi_clk_gate,
  output logic                                 spi_en,
  output logic                                 shutdown_sense_en,
  output logic                                 block_bufs,
  output logic                                 n_shutdown_force,
  output logic                                 n_shutdown_rst,
  output logic                                 ps_interrupt,
  output logic [31:0]                          status_word
);
  import hw_mgr_pkg::*;

  state_t              state;
  state_t              state_next;
  logic [STATUS_W-1:0] status_code;
  logic [BOARD_W-1:0]  board_num;

  logic                timer_clear;
  logic [TIMER_W-1:0]  timer_limit;
  logic [TIMER_W-1:0]  count;
  logic                expired;

  logic                start_fault;
  logic [STATUS_W-1:0] start_code;
  logic                boot_fault;
  logic [STATUS_W-1:0] boot_code;
  logic [BOARD_W-1:0]  boot_board;
  logic                run_fault;
  logic [STATUS_W-1:0] run_code;
  logic [BOARD_W-1:0]  run_board;

  // Board in the top bits, state in the bottom nibble
  assign status_word = {board_num, status_code, state};

  hw_sequencer #(
    .SHUTDOWN_FORCE_DELAY (SHUTDOWN_FORCE_DELAY),
    .SHUTDOWN_RESET_PULSE (SHUTDOWN_RESET_PULSE),
    .SHUTDOWN_RESET_DELAY (SHUTDOWN_RESET_DELAY),
    .SPI_RESET_WAIT       (SPI_RESET_WAIT),
    .SPI_START_WAIT       (SPI_START_WAIT)
  ) u_sequencer (
    .clk, .aresetn, .sys_en, .ext_en, .spi_off,
    .start_fault, .start_code,
    .boot_fault, .boot_code, .boot_board,
    .run_fault, .run_code, .run_board,
    .count, .expired, .timer_clear, .timer_limit,
    .state, .state_next, .status_code, .board_num
  );

  seq_timer u_timer (
    .clk, .aresetn,
    .clear (timer_clear),
    .limit (timer_limit),
    .count, .expired
  );

  fault_arbiter u_arbiter (
    .sys_en, .ext_en, .lock_viol, .cfg_oob,
    .shutdown_sense, .over_thresh, .dac_boot_fail, .adc_boot_fail,
    .start_fault, .start_code,
    .boot_fault, .boot_code, .boot_board,
    .run_fault, .run_code, .run_board
  );

  power_ctrl u_power (
    .clk, .aresetn, .state, .state_next,
    .unlock_cfg, .spi_clk_gate, .spi_en, .shutdown_sense_en,
    .block_bufs, .n_shutdown_force, .n_shutdown_rst, .ps_interrupt
  );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,  // 25 MHz test clock
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic aresetn
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset held over the first rising edges
  initial begin
    aresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    aresetn = 1'b1;  // Released away from the active edge
  end

endmodule

// ==== tb_shim_hw_manager.sv ====
`timescale 1ns/1ps

module tb_shim_hw_manager;
  import hw_mgr_pkg::*;

  // Short delays so one sequence takes tens of cycles
  localparam int unsigned SHUTDOWN_FORCE_DELAY = 8;
  localparam int unsigned SHUTDOWN_RESET_PULSE = 5;
  localparam int unsigned SHUTDOWN_RESET_DELAY = 12;
  localparam int unsigned SPI_RESET_WAIT       = 20;
  localparam int unsigned SPI_START_WAIT       = 16;

  localparam int PERIOD_NS   = 40;
  localparam int N_SCENARIOS = 14;
  localparam int DELAY_SUM   = SHUTDOWN_FORCE_DELAY + SHUTDOWN_RESET_PULSE +
                               SHUTDOWN_RESET_DELAY + SPI_RESET_WAIT + SPI_START_WAIT +
                               int'(SPI_SETTLE_CYCLES);
  localparam int WAIT_LIMIT  = DELAY_SUM + 20;  // Longest legal stay in one state
  localparam longint WATCHDOG_NS = longint'(WAIT_LIMIT * N_SCENARIOS + 200) * PERIOD_NS;

  logic                    clk;
  logic                    aresetn;
  logic                    sys_en;
  logic                    spi_off;
  logic                    ext_en;
  logic                    lock_viol;
  logic [N_CFG_CHECKS-1:0] cfg_oob;
  logic [N_BOARDS-1:0]     shutdown_sense;
  logic [N_BOARDS-1:0]     over_thresh;
  logic [N_BOARDS-1:0]     dac_boot_fail;
  logic [N_BOARDS-1:0]     adc_boot_fail;
  logic                    unlock_cfg;
  logic                    spi_clk_gate;
  logic                    spi_en;
  logic                    shutdown_sense_en;
  logic                    block_bufs;
  logic                    n_shutdown_force;
  logic                    n_shutdown_rst;
  logic                    ps_interrupt;
  logic [31:0]             status_word;

  logic [31:0] lcg_state;
  logic [31:0] vec_a;          // Random fault vectors
  logic [31:0] vec_b;
  logic        spi_stuck;      // SPI model never leaves reset
  int          spi_delay;      // Cycles from spi_en to spi_off low
  int          spi_wait;
  logic [3:0]  prev_st;

  tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(3)) u_clock (.clk, .aresetn);

  shim_hw_manager #(
    .SHUTDOWN_FORCE_DELAY (SHUTDOWN_FORCE_DELAY),
    .SHUTDOWN_RESET_PULSE (SHUTDOWN_RESET_PULSE),
    .SHUTDOWN_RESET_DELAY (SHUTDOWN_RESET_DELAY),
    .SPI_RESET_WAIT       (SPI_RESET_WAIT),
    .SPI_START_WAIT       (SPI_START_WAIT)
  ) DUT (
    .clk, .aresetn, .sys_en, .spi_off, .ext_en, .lock_viol, .cfg_oob,
    .shutdown_sense, .over_thresh, .dac_boot_fail, .adc_boot_fail,
    .unlock_cfg, .spi_clk_gate, .spi_en, .shutdown_sense_en, .block_bufs,
    .n_shutdown_force, .n_shutdown_rst, .ps_interrupt, .status_word
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Nonzero vector of the given width
  function automatic logic [31:0] rand_vec(input int width);
    logic [31:0] v;
    v = (next_rand() >> 8) & ((32'd1 << width) - 1);
    if (v == 0) v = 32'd1 << (next_rand() % width);  // Force one flag
    return v;
  endfunction

  function automatic int lowest_bit(input logic [31:0] v);
    for (int i = 0; i < 32; i++) begin
      if (v[i]) return i;
    end
    return 0;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    assert (actual === expected) else begin
      fail_run($sformatf("error at %0t ns: %s expected 0x%0h, got 0x%0h",
                         $time, name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    check_value(name, {31'b0, actual}, {31'b0, expected});
  endtask

  task automatic check_state(input state_t st);
    check_value("state", {28'b0, status_word[3:0]}, 32'(st));
  endtask

  // Behavioral SPI block, off while disabled, running a few cycles after enable
  always @(negedge clk) begin
    if (spi_en !== 1'b1) begin
      spi_off  <= 1'b1;
      spi_wait <= 0;
    end else if (!spi_stuck) begin
      if (spi_wait >= spi_delay) spi_off <= 1'b0;
      else spi_wait <= spi_wait + 1;
    end
  end

  // Control decode and interrupt pulse follow the state on every cycle
  always @(negedge clk) begin
    logic [3:0] st;
    st = status_word[3:0];
    if (aresetn === 1'b1) begin
      check_bit("n_shutdown_force", n_shutdown_force, st inside {POWER_ON_CTRL_BRD,
                CONFIRM_SPI_START, POWER_ON_AMP_BRD, AMP_POWER_WAIT, RUNNING});
      check_bit("spi_en", spi_en, st inside {CONFIRM_SPI_START, POWER_ON_AMP_BRD,
                AMP_POWER_WAIT, RUNNING});
      check_bit("spi_clk_gate", spi_clk_gate, st inside {CONFIRM_SPI_START,
                POWER_ON_AMP_BRD, AMP_POWER_WAIT, RUNNING});
      check_bit("n_shutdown_rst", n_shutdown_rst, st != POWER_ON_AMP_BRD);
      check_bit("shutdown_sense_en", shutdown_sense_en, st == RUNNING);
      check_bit("block_bufs", block_bufs, st != RUNNING);
      check_bit("unlock_cfg", unlock_cfg, (st == IDLE) || (st == HALTED));
      check_bit("ps_interrupt", ps_interrupt,
                ((st == RUNNING) || (st == HALTED)) && (st != prev_st));
    end
    prev_st = st;
  end

  task automatic wait_state(input state_t st);
    int n;
    n = 0;
    while (status_word[3:0] != st) begin
      if (n == WAIT_LIMIT) fail_run($sformatf("state %s never reached", st.name()));
      @(negedge clk);
      n++;
    end
  endtask

  // Stay in st for exactly the given number of cycles
  task automatic hold_state(input state_t st, input int cycles);
    int n;
    n = 0;
    check_state(st);
    while ((status_word[3:0] == st) && (n < cycles + 5)) begin
      @(negedge clk);
      n++;
    end
    check_value($sformatf("cycles in %s", st.name()), n, cycles);
  endtask

  task automatic start_power_up();
    spi_delay = 1 + int'(next_rand() % 4);
    sys_en    = 1'b1;
  endtask

  // One HALTING cycle, then HALTED with the cause and safe controls
  task automatic expect_halt(input logic [31:0] code, input int board);
    @(negedge clk);
    check_state(HALTING);
    @(negedge clk);
    check_state(HALTED);
    check_value("status code", {7'b0, status_word[28:4]}, code);
    check_value("board", {29'b0, status_word[31:29]}, 32'(board));
    check_bit("unlock_cfg", unlock_cfg, 1'b1);
    check_bit("ps_interrupt", ps_interrupt, 1'b1);
    check_bit("spi_en", spi_en, 1'b0);
    check_bit("n_shutdown_force", n_shutdown_force, 1'b0);
    check_bit("block_bufs", block_bufs, 1'b1);
  endtask

  task automatic return_to_idle();
    sys_en         = 1'b0;
    ext_en         = 1'b1;
    cfg_oob        = '0;
    shutdown_sense = '0;
    over_thresh    = '0;
    dac_boot_fail  = '0;
    adc_boot_fail  = '0;
    @(negedge clk);
    check_state(IDLE);
    check_value("status code", {7'b0, status_word[28:4]}, 32'(STS_OK));
    check_value("board", {29'b0, status_word[31:29]}, 32'd0);
  endtask

  task automatic ext_drop_in(input state_t st);
    start_power_up();
    wait_state(st);
    ext_en = 1'b0;  // Deadman released
    expect_halt(32'(STS_EXT_SHUTDOWN), 0);
    return_to_idle();
  endtask

  initial begin
    #(WATCHDOG_NS);
    fail_run($sformatf("timeout: run still going after %0d ns", WATCHDOG_NS));
  end

  initial begin
    lcg_state      = 32'hb14e_25b7;
    sys_en         = 1'b0;
    spi_off        = 1'b1;
    ext_en         = 1'b1;
    lock_viol      = 1'b0;
    cfg_oob        = '0;
    shutdown_sense = '0;
    over_thresh    = '0;
    dac_boot_fail  = '0;
    adc_boot_fail  = '0;
    spi_stuck      = 1'b0;
    spi_delay      = 2;
    spi_wait       = 0;
    prev_st        = IDLE;
    wait (aresetn === 1'b1);
    @(negedge clk);
    check_state(IDLE);
    check_value("status code", {7'b0, status_word[28:4]}, 32'(STS_OK));

    // Clean power-up with each delay timed
    start_power_up();
    @(negedge clk);
    hold_state(CONFIRM_SPI_RST, int'(SPI_SETTLE_CYCLES) + 1);
    hold_state(POWER_ON_CTRL_BRD, SHUTDOWN_FORCE_DELAY + 1);
    wait_state(POWER_ON_AMP_BRD);
    hold_state(POWER_ON_AMP_BRD, SHUTDOWN_RESET_PULSE + 1);
    hold_state(AMP_POWER_WAIT, SHUTDOWN_RESET_DELAY + 1);
    check_state(RUNNING);
    check_bit("ps_interrupt", ps_interrupt, 1'b1);
    @(negedge clk);
    check_bit("ps_interrupt", ps_interrupt, 1'b0);  // Single pulse

    // Sense beats threshold in RUNNING
    vec_a          = rand_vec(N_BOARDS);
    vec_b          = rand_vec(N_BOARDS);
    shutdown_sense = vec_a[N_BOARDS-1:0];
    over_thresh    = vec_b[N_BOARDS-1:0];
    expect_halt(32'(STS_SHUTDOWN_SENSE), lowest_bit(vec_a));
    return_to_idle();

    start_power_up();
    wait_state(RUNNING);
    vec_a       = rand_vec(N_BOARDS);
    over_thresh = vec_a[N_BOARDS-1:0];
    expect_halt(32'(STS_OVER_THRESH), lowest_bit(vec_a));
    return_to_idle();

    // Config flag seen before the sequence starts
    vec_a   = rand_vec(N_CFG_CHECKS);
    cfg_oob = vec_a[N_CFG_CHECKS-1:0];
    start_power_up();
    expect_halt(32'(STS_CFG_OOB_BASE) + 32'(lowest_bit(vec_a)), 0);
    return_to_idle();

    // Boot failures while SPI is held in reset
    spi_stuck = 1'b1;
    start_power_up();
    wait_state(CONFIRM_SPI_START);
    vec_a         = rand_vec(N_BOARDS);
    vec_b         = rand_vec(N_BOARDS);
    dac_boot_fail = vec_a[N_BOARDS-1:0];
    adc_boot_fail = vec_b[N_BOARDS-1:0];
    expect_halt(32'(STS_DAC_BOOT_FAIL), lowest_bit(vec_a));
    return_to_idle();

    start_power_up();
    wait_state(CONFIRM_SPI_START);
    vec_b         = rand_vec(N_BOARDS);
    adc_boot_fail = vec_b[N_BOARDS-1:0];
    expect_halt(32'(STS_ADC_BOOT_FAIL), lowest_bit(vec_b));
    return_to_idle();

    start_power_up();
    wait_state(CONFIRM_SPI_START);
    repeat (SPI_START_WAIT) @(negedge clk);  // Last cycle before timeout
    check_state(CONFIRM_SPI_START);
    expect_halt(32'(STS_SPI_START_TIMEOUT), 0);
    return_to_idle();
    spi_stuck = 1'b0;

    // Deadman loss in every sequencing state
    ext_drop_in(IDLE);
    ext_drop_in(CONFIRM_SPI_RST);
    ext_drop_in(POWER_ON_CTRL_BRD);
    ext_drop_in(CONFIRM_SPI_START);
    ext_drop_in(POWER_ON_AMP_BRD);
    ext_drop_in(AMP_POWER_WAIT);

    $display("No errors");
    $finish;
  end

endmodule
